// File: logic/rp_params.svh
/* widths, region map and register offsets shared by the whole design
   region field sits at addr[22:20], register offset at addr[7:0]
   bits in between are ignored by every slave */
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

`define RP_SMP_W          14             // ADC/DAC sample width
`define RP_ADDR_W         32
`define RP_DATA_W         32
`define RP_REGION_LSB     20             // 3 bit region field starts here
`define RP_N_REGIONS      8
`define RP_REG_OFS_W      8
`define RP_PHASE_W        32             // sawtooth accumulator
`define RP_GAIN_W         16             // signed gain
`define RP_GAIN_FRAC      8              // 256 is unity

// region map
`define RP_HK_REGION      3'd0
`define RP_GEN_REGION     3'd1
`define RP_PID_REGION     3'd2           // regions above are unused

`define RP_HK_ID          32'h5250_0001

// housekeeping
`define RP_ID_OFS         8'h00
`define RP_LED_OFS        8'h04
// generator
`define RP_GEN_CTRL_OFS   8'h00
`define RP_GEN_STEP_A_OFS 8'h04
`define RP_GEN_STEP_B_OFS 8'h08
// controller
`define RP_PID_SP_A_OFS   8'h00
`define RP_PID_SP_B_OFS   8'h04
`define RP_PID_GAIN_A_OFS 8'h08
`define RP_PID_GAIN_B_OFS 8'h0C

`endif

// File: logic/rp_pkg.sv
/* bus structs, sample types and small helpers
   samples are two's complement, the pins use the negative slope offset code */
`include "rp_params.svh"

package rp_pkg;

  typedef struct packed {
    logic [`RP_ADDR_W-1:0]   addr;
    logic [`RP_DATA_W-1:0]   wdata;
    logic [`RP_DATA_W/8-1:0] sel;    // byte select for writes
    logic                    wen;    // one cycle strobe
    logic                    ren;    // one cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [`RP_DATA_W-1:0] rdata;
    logic                  err;
    logic                  ack;
  } sys_rsp_t;

  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  typedef struct packed {
    sample_t cha;
    sample_t chb;
  } sample_pair_t;

  localparam int SMP_MAX = 2**(`RP_SMP_W-1) - 1;
  localparam int SMP_MIN = -(2**(`RP_SMP_W-1));

  // merge selected bytes of wdata into the old value
  function automatic logic [`RP_DATA_W-1:0] apply_sel(
    input logic [`RP_DATA_W-1:0]   old_val,
    input logic [`RP_DATA_W-1:0]   wdata,
    input logic [`RP_DATA_W/8-1:0] sel
  );
    logic [`RP_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < `RP_DATA_W/8; i++)
    begin
      if (sel[i])
        res[i*8 +: 8] = wdata[i*8 +: 8];
    end
    return res;
  endfunction

  // clamp to sample range, input wide enough for the controller product
  function automatic sample_t sat_sample(input logic signed [31:0] x);
    if (x > SMP_MAX)
      return sample_t'(SMP_MAX);
    else if (x < SMP_MIN)
      return sample_t'(SMP_MIN);
    return x[`RP_SMP_W-1:0];
  endfunction

  // msb kept, rest inverted; same mapping both ways
  function automatic logic [`RP_SMP_W-1:0] flip_code(input logic [`RP_SMP_W-1:0] x);
    return {x[`RP_SMP_W-1], ~x[`RP_SMP_W-2:0]};
  endfunction

endpackage

// File: logic/sys_bus_decoder.sv
/* one host, eight regions selected by addr[22:20]
   host must hold addr until ack, the response mux follows the live address
   regions 3 to 7 are answered here, one cycle late, rdata 0 and err 0 */
`timescale 1ns/1ps
`include "rp_params.svh"

module sys_bus_decoder (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sys_req_t host_req_i,
  output rp_pkg::sys_rsp_t host_rsp_o,
  output rp_pkg::sys_req_t hk_req_o,
  output rp_pkg::sys_req_t gen_req_o,
  output rp_pkg::sys_req_t pid_req_o,
  input  rp_pkg::sys_rsp_t hk_rsp_i,
  input  rp_pkg::sys_rsp_t gen_rsp_i,
  input  rp_pkg::sys_rsp_t pid_rsp_i
);

  localparam int REGION_W = $clog2(`RP_N_REGIONS);

  logic [REGION_W-1:0]      region;
  logic [`RP_N_REGIONS-1:0] cs;           // one hot chip select
  logic                     unused_sel;
  logic                     unused_ack_q;

  assign region     = host_req_i.addr[`RP_REGION_LSB +: REGION_W];
  assign unused_sel = (region > `RP_PID_REGION);

  //////////////////////////////
  // request side
  //////////////////////////////

  always_comb
  begin
    cs         = '0;
    cs[region] = 1'b1;

    hk_req_o      = host_req_i;
    hk_req_o.wen  = host_req_i.wen & cs[`RP_HK_REGION];
    hk_req_o.ren  = host_req_i.ren & cs[`RP_HK_REGION];
    gen_req_o     = host_req_i;
    gen_req_o.wen = host_req_i.wen & cs[`RP_GEN_REGION];
    gen_req_o.ren = host_req_i.ren & cs[`RP_GEN_REGION];
    pid_req_o     = host_req_i;
    pid_req_o.wen = host_req_i.wen & cs[`RP_PID_REGION];
    pid_req_o.ren = host_req_i.ren & cs[`RP_PID_REGION];
  end

  // stand-in slave for empty regions
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      unused_ack_q <= 1'b0;
    else
      unused_ack_q <= (host_req_i.wen | host_req_i.ren) & unused_sel;
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb
  begin
    case (region)
      `RP_HK_REGION:  host_rsp_o = hk_rsp_i;
      `RP_GEN_REGION: host_rsp_o = gen_rsp_i;
      `RP_PID_REGION: host_rsp_o = pid_rsp_i;
      default:        host_rsp_o = '{rdata: '0, err: 1'b0, ack: unused_ack_q};
    endcase
  end

endmodule

// File: logic/housekeeping_regs.sv
/* ID and LED registers, region 0
   the ID is read only, writes to it are ignored without error
   LED takes byte 0 of a write when sel[0] is set */
`timescale 1ns/1ps
`include "rp_params.svh"

module housekeeping_regs (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sys_req_t req_i,
  output rp_pkg::sys_rsp_t rsp_o,
  output logic [7:0]       led_o
);

  logic [`RP_REG_OFS_W-1:0] ofs;
  logic                     known;    // offset hits a register
  logic [`RP_DATA_W-1:0]    rd_val;
  logic [`RP_DATA_W-1:0]    wr_val;
  logic [7:0]               led_q;
  logic                     ack_q;
  logic [`RP_DATA_W-1:0]    rdata_q;
  logic                     err_q;

  assign ofs    = req_i.addr[`RP_REG_OFS_W-1:0];
  assign wr_val = rp_pkg::apply_sel(rd_val, req_i.wdata, req_i.sel);

  // offset decode
  always_comb
  begin
    known  = 1'b1;
    rd_val = '0;
    case (ofs)
      `RP_ID_OFS:  rd_val = `RP_HK_ID;
      `RP_LED_OFS: rd_val = `RP_DATA_W'(led_q);
      default:     known  = 1'b0;    // rdata stays 0
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      led_q <= '0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;    // always one cycle later
      if (req_i.wen && ofs == `RP_LED_OFS)
        led_q <= wr_val[7:0];
    end
  end

  // response payload
  always_ff @(posedge adc_clk)
  begin
    rdata_q <= rd_val;
    err_q   <= ~known;
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};
  assign led_o = led_q;

endmodule

// File: logic/sawtooth_gen.sv
/* two sawtooth channels on region 1
   ctrl bit 0 enables A, bit 1 enables B; a disabled phase is held at 0
   output is the top 14 phase bits, so step k<<18 moves the sample by k */
`timescale 1ns/1ps
`include "rp_params.svh"

module sawtooth_gen (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::sys_req_t     req_i,
  output rp_pkg::sys_rsp_t     rsp_o,
  output rp_pkg::sample_pair_t wave_o
);

  localparam int MSB = `RP_PHASE_W - 1;

  logic [`RP_REG_OFS_W-1:0] ofs;
  logic                     known;
  logic [`RP_DATA_W-1:0]    rd_val;
  logic [`RP_DATA_W-1:0]    wr_val;
  logic [1:0]               en_q;           // per channel enable
  logic [`RP_PHASE_W-1:0]   step_q  [2];
  logic [`RP_PHASE_W-1:0]   phase_q [2];
  logic                     ack_q;
  logic [`RP_DATA_W-1:0]    rdata_q;
  logic                     err_q;

  assign ofs    = req_i.addr[`RP_REG_OFS_W-1:0];
  assign wr_val = rp_pkg::apply_sel(rd_val, req_i.wdata, req_i.sel);

  always_comb
  begin
    known  = 1'b1;
    rd_val = '0;
    case (ofs)
      `RP_GEN_CTRL_OFS:   rd_val = `RP_DATA_W'(en_q);
      `RP_GEN_STEP_A_OFS: rd_val = step_q[0];
      `RP_GEN_STEP_B_OFS: rd_val = step_q[1];
      default:            known  = 1'b0;
    endcase
  end

  //////////////////////////////
  // bus registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      en_q      <= '0;
      step_q[0] <= '0;
      step_q[1] <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      if (req_i.wen)
      begin
        case (ofs)
          `RP_GEN_CTRL_OFS:   en_q      <= wr_val[1:0];
          `RP_GEN_STEP_A_OFS: step_q[0] <= wr_val;
          `RP_GEN_STEP_B_OFS: step_q[1] <= wr_val;
          default:            ;      // nothing to write
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= rd_val;
    err_q   <= ~known;
  end

  //////////////////////////////
  // phase accumulators
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      phase_q[0] <= '0;
      phase_q[1] <= '0;
    end
    else
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        if (en_q[ch])
          phase_q[ch] <= phase_q[ch] + step_q[ch];   // wraps mod 2^32
        else
          phase_q[ch] <= '0;
      end
    end
  end

  assign rsp_o  = '{rdata: rdata_q, err: err_q, ack: ack_q};
  assign wave_o = '{cha: phase_q[0][MSB -: `RP_SMP_W], chb: phase_q[1][MSB -: `RP_SMP_W]};

endmodule

// File: logic/p_controller.sv
/* two proportional controllers on region 2
   out = sat((setpoint - meas) * gain >>> 8), gain 256 is unity
   setpoint uses the low 14 bits of a write, gain the low 16, both signed
   output is registered, one cycle after meas_i */
`timescale 1ns/1ps
`include "rp_params.svh"

module p_controller (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::sys_req_t     req_i,
  output rp_pkg::sys_rsp_t     rsp_o,
  input  rp_pkg::sample_pair_t meas_i,
  output rp_pkg::sample_pair_t ctrl_o
);

  localparam int W      = `RP_SMP_W;
  localparam int PROD_W = `RP_SMP_W + 1 + `RP_GAIN_W;   // 15 bit error times gain

  logic [`RP_REG_OFS_W-1:0]     ofs;
  logic                         known;
  logic [`RP_DATA_W-1:0]        rd_val;
  logic [`RP_DATA_W-1:0]        wr_val;
  rp_pkg::sample_t              sp_q   [2];
  logic signed [`RP_GAIN_W-1:0] gain_q [2];
  rp_pkg::sample_t              meas   [2];
  logic signed [W:0]            diff   [2];   // setpoint minus meas
  logic signed [PROD_W-1:0]     prod   [2];
  logic signed [PROD_W-1:0]     scaled [2];
  rp_pkg::sample_t              out_q  [2];
  logic                         ack_q;
  logic [`RP_DATA_W-1:0]        rdata_q;
  logic                         err_q;

  assign ofs     = req_i.addr[`RP_REG_OFS_W-1:0];
  assign wr_val  = rp_pkg::apply_sel(rd_val, req_i.wdata, req_i.sel);
  assign meas[0] = meas_i.cha;
  assign meas[1] = meas_i.chb;

  always_comb
  begin
    known  = 1'b1;
    rd_val = '0;
    case (ofs)
      `RP_PID_SP_A_OFS:   rd_val = `RP_DATA_W'(sp_q[0]);    // sign extended
      `RP_PID_SP_B_OFS:   rd_val = `RP_DATA_W'(sp_q[1]);
      `RP_PID_GAIN_A_OFS: rd_val = `RP_DATA_W'(gain_q[0]);
      `RP_PID_GAIN_B_OFS: rd_val = `RP_DATA_W'(gain_q[1]);
      default:            known  = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sp_q[0]   <= '0;
      sp_q[1]   <= '0;
      gain_q[0] <= '0;
      gain_q[1] <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      if (req_i.wen)
      begin
        case (ofs)
          `RP_PID_SP_A_OFS:   sp_q[0]   <= wr_val[W-1:0];
          `RP_PID_SP_B_OFS:   sp_q[1]   <= wr_val[W-1:0];
          `RP_PID_GAIN_A_OFS: gain_q[0] <= wr_val[`RP_GAIN_W-1:0];
          `RP_PID_GAIN_B_OFS: gain_q[1] <= wr_val[`RP_GAIN_W-1:0];
          default:            ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= rd_val;
    err_q   <= ~known;
  end

  //////////////////////////////
  // datapath
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
    begin
      diff[ch]   = $signed({sp_q[ch][W-1], sp_q[ch]}) - $signed({meas[ch][W-1], meas[ch]});
      prod[ch]   = PROD_W'(diff[ch]) * PROD_W'(gain_q[ch]);
      scaled[ch] = prod[ch] >>> `RP_GAIN_FRAC;     // drop gain fraction
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      out_q[0] <= '0;
      out_q[1] <= '0;
    end
    else
    begin
      out_q[0] <= rp_pkg::sat_sample(32'(scaled[0]));
      out_q[1] <= rp_pkg::sat_sample(32'(scaled[1]));
    end
  end

  assign rsp_o  = '{rdata: rdata_q, err: err_q, ack: ack_q};
  assign ctrl_o = '{cha: out_q[0], chb: out_q[1]};

endmodule

// File: logic/analog_front.sv
/* ADC capture and DAC output stage
   pins carry the negative slope offset code, inside everything is signed
   ADC pins are registered once, decode is combinational behind that
   DAC = code(sat(wave + ctrl)), registered; after reset code of 0, 14'h1FFF */
`timescale 1ns/1ps
`include "rp_params.svh"

module analog_front (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [13:0]          adc_dat_a_i,
  input  logic [13:0]          adc_dat_b_i,
  output rp_pkg::sample_pair_t meas_o,
  input  rp_pkg::sample_pair_t wave_i,
  input  rp_pkg::sample_pair_t ctrl_i,
  output logic [13:0]          dac_dat_a_o,
  output logic [13:0]          dac_dat_b_o
);

  localparam int W = `RP_SMP_W;

  logic [W-1:0]    adc_q  [2];    // raw pin codes
  rp_pkg::sample_t adc_s  [2];
  rp_pkg::sample_t wave_s [2];
  rp_pkg::sample_t ctrl_s [2];
  logic signed [W:0] sum  [2];    // one guard bit
  rp_pkg::sample_t dac_s  [2];
  logic [W-1:0]    dac_q  [2];

  assign wave_s[0] = wave_i.cha;
  assign wave_s[1] = wave_i.chb;
  assign ctrl_s[0] = ctrl_i.cha;
  assign ctrl_s[1] = ctrl_i.chb;

  //////////////////////////////
  // ADC side
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    adc_q[0] <= adc_dat_a_i;
    adc_q[1] <= adc_dat_b_i;
  end

  //////////////////////////////
  // DAC side
  //////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
    begin
      adc_s[ch] = rp_pkg::flip_code(adc_q[ch]);
      sum[ch]   = $signed({wave_s[ch][W-1], wave_s[ch]}) + $signed({ctrl_s[ch][W-1], ctrl_s[ch]});
      dac_s[ch] = rp_pkg::sat_sample(32'(sum[ch]));   // clamp to 14 bits
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_q[0] <= rp_pkg::flip_code('0);   // mid scale
      dac_q[1] <= rp_pkg::flip_code('0);
    end
    else
    begin
      dac_q[0] <= rp_pkg::flip_code(dac_s[0]);
      dac_q[1] <= rp_pkg::flip_code(dac_s[1]);
    end
  end

  assign meas_o      = '{cha: adc_s[0], chb: adc_s[1]};
  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];

endmodule

// File: logic/rp_top.sv
/* two channel signal path and host register bus, single clock adc_clk
   region 0 housekeeping, 1 sawtooth, 2 controller, 3..7 empty
   ADC pin to DAC pin latency is 3 cycles */
`timescale 1ns/1ps

module rp_top (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sys_req_t sys_req_i,
  output rp_pkg::sys_rsp_t sys_rsp_o,
  input  logic [13:0]      adc_dat_a_i,
  input  logic [13:0]      adc_dat_b_i,
  output logic [13:0]      dac_dat_a_o,
  output logic [13:0]      dac_dat_b_o,
  output logic [7:0]       led_o
);

  rp_pkg::sys_req_t     hk_req, gen_req, pid_req;
  rp_pkg::sys_rsp_t     hk_rsp, gen_rsp, pid_rsp;
  rp_pkg::sample_pair_t meas;      // decoded ADC
  rp_pkg::sample_pair_t wave;      // sawtooth
  rp_pkg::sample_pair_t ctrl;      // controller out

  //////////////////////////////
  // bus
  //////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .host_req_i (sys_req_i),
    .host_rsp_o (sys_rsp_o),
    .hk_req_o   (hk_req),
    .gen_req_o  (gen_req),
    .pid_req_o  (pid_req),
    .hk_rsp_i   (hk_rsp),
    .gen_rsp_i  (gen_rsp),
    .pid_rsp_i  (pid_rsp)
  );

  housekeeping_regs i_hk (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (hk_req),
    .rsp_o   (hk_rsp),
    .led_o   (led_o)
  );

  //////////////////////////////
  // signal path
  //////////////////////////////

  sawtooth_gen i_gen (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (gen_req),
    .rsp_o   (gen_rsp),
    .wave_o  (wave)
  );

  p_controller i_pid (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (pid_req),
    .rsp_o   (pid_rsp),
    .meas_i  (meas),
    .ctrl_o  (ctrl)
  );

  analog_front i_analog (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .meas_o      (meas),
    .wave_i      (wave),
    .ctrl_i      (ctrl),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// File: testbench/tb_rp_top.sv
/* testbench for rp_top, one clock, all inputs driven on the falling edge
   expected values follow the code rule and the controller equation
   the first failed check or a timeout ends the run */
`timescale 1ns/1ps
`include "rp_params.svh"

module tb_rp_top;

  localparam int MAX_CYCLES = 5000;     // run needs well under 1000
  localparam int FULL       = 16384;    // 14 bit code span

  logic             adc_clk;
  logic             rst_n;
  rp_pkg::sys_req_t sys_req;
  rp_pkg::sys_rsp_t sys_rsp;
  logic [13:0]      adc_a;
  logic [13:0]      adc_b;
  logic [13:0]      dac_a;
  logic [13:0]      dac_b;
  logic [7:0]       led;
  int               cycle_cnt = 0;
  logic [31:0]      rd_data;            // last bus response
  logic             rd_err;

  rp_top UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  always #20 adc_clk = ~adc_clk;       // 40 ns period

  //////////////////////////////
  // failure exits
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("MISMATCH at %0t ns: %s", $time, msg));
  endtask

  always @(posedge adc_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      abort_run($sformatf("timeout, no result after %0d cycles", MAX_CYCLES));
  end

  // strobe gets its ack exactly one cycle later
  assert property (@(posedge adc_clk) disable iff (!rst_n)
    (sys_req.wen || sys_req.ren) |=> sys_rsp.ack)
  else report_mismatch("strobe not acknowledged on the next cycle");

  assert property (@(posedge adc_clk) disable iff (!rst_n)
    sys_rsp.ack |-> $past(sys_req.wen || sys_req.ren))
  else report_mismatch("ack without a strobe one cycle before");

  //////////////////////////////
  // reference model
  //////////////////////////////

  // negative slope offset code with 0x1FFF as zero and 0x0000 as full positive
  function automatic int decode_code(input logic [13:0] code);
    return 8191 - int'(code);
  endfunction

  function automatic logic [13:0] encode_sample(input int v);
    return 14'(8191 - v);
  endfunction

  function automatic int clamp14(input int x);
    if (x > 8191)
      return 8191;
    if (x < -8192)
      return -8192;
    return x;
  endfunction

  function automatic int p_ctrl_ref(input int sp, input int meas, input int gain);
    return clamp14(((sp - meas) * gain) >>> 8);   // 256 is unity
  endfunction

  // sum of one of the four wave levels of step 2^30 and a fixed ctrl
  function automatic bit in_sum_set(input int val, input int ctrl);
    int w;
    for (int n = 0; n < 4; n++)
    begin
      w = n * 4096 - 8192;
      if (val == clamp14(w + ctrl))
        return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] reg_addr(input int region, input int ofs);
    return (32'(region) << `RP_REGION_LSB) | 32'(ofs);
  endfunction

  //////////////////////////////
  // bus and stimulus tasks
  //////////////////////////////

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic write);
    int waited;
    waited = 0;
    @(negedge adc_clk);
    sys_req.addr  = addr;                // held until the next access
    sys_req.wdata = data;
    sys_req.sel   = 4'hF;
    sys_req.wen   = write;
    sys_req.ren   = ~write;
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    while (!sys_rsp.ack && waited < 4)
    begin
      @(negedge adc_clk);
      waited++;
    end
    assert (sys_rsp.ack) else abort_run($sformatf("no bus ack for address %h", addr));
    rd_data = sys_rsp.rdata;
    rd_err  = sys_rsp.err;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bus_access(addr, data, 1'b1);
  endtask

  task automatic bus_read(input logic [31:0] addr);
    bus_access(addr, 32'h0, 1'b0);
  endtask

  task automatic set_gains(input int gain);
    bus_write(reg_addr(2, `RP_PID_GAIN_A_OFS), 32'(gain));
    bus_write(reg_addr(2, `RP_PID_GAIN_B_OFS), 32'(gain));
  endtask

  // called on a falling edge with the generator off and setpoints 0
  task automatic check_adc_path(input logic [13:0] code_a, input logic [13:0] code_b,
                                input int gain);
    logic [13:0] exp_a;
    logic [13:0] exp_b;
    exp_a = encode_sample(p_ctrl_ref(0, decode_code(code_a), gain));
    exp_b = encode_sample(p_ctrl_ref(0, decode_code(code_b), gain));
    adc_a = code_a;
    adc_b = code_b;
    repeat (3) @(negedge adc_clk);       // pin reg, controller, dac reg
    assert (dac_a == exp_a)
    else report_mismatch($sformatf("dac A %h, expected %h, adc %h", dac_a, exp_a, code_a));
    assert (dac_b == exp_b)
    else report_mismatch($sformatf("dac B %h, expected %h, adc %h", dac_b, exp_b, code_b));
  endtask

  // idle code due within 3 cycles of the disable write
  task automatic check_dac_idle(input bit chan_b);
    int waited;
    waited = 0;
    while ((chan_b ? dac_b : dac_a) != 14'h1FFF && waited < 2)
    begin
      @(negedge adc_clk);
      waited++;
    end
    assert ((chan_b ? dac_b : dac_a) == 14'h1FFF)
    else report_mismatch($sformatf("dac %s not idle after disable", chan_b ? "B" : "A"));
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    logic [7:0]  led_val;
    logic [31:0] wr_val;
    int          k_a;
    int          k_b;
    int          prev_a;
    int          prev_b;
    int          cur_a;
    int          cur_b;
    int          sat_hits;
    int          low_hits_a;

    adc_clk = 1'b0;
    rst_n   = 1'b0;
    sys_req = '0;
    adc_a   = 14'h1FFF;                  // zero volts
    adc_b   = 14'h1FFF;
    void'($urandom(32'hf877_9709));
    repeat (10) @(negedge adc_clk);
    rst_n = 1'b1;

    // reset state
    assert (led == 8'h00) else report_mismatch("led_o not 0 after reset");
    assert (dac_a == 14'h1FFF && dac_b == 14'h1FFF)
    else report_mismatch($sformatf("dac %h/%h after reset", dac_a, dac_b));

    // housekeeping
    bus_read(reg_addr(0, `RP_ID_OFS));
    assert (rd_data == `RP_HK_ID && !rd_err)
    else report_mismatch($sformatf("ID read %h", rd_data));
    wr_val  = $urandom;
    led_val = wr_val[7:0];
    bus_write(reg_addr(0, `RP_LED_OFS), wr_val);
    assert (led == led_val) else report_mismatch($sformatf("led_o %h, wrote %h", led, led_val));
    bus_read(reg_addr(0, `RP_LED_OFS));
    assert (rd_data == {24'h0, led_val} && !rd_err)
    else report_mismatch($sformatf("LED read %h, wrote %h", rd_data, led_val));
    bus_read(reg_addr(0, 8'h10));        // no register here
    assert (rd_err && rd_data == 32'h0)
    else report_mismatch($sformatf("bad offset gave err %b rdata %h", rd_err, rd_data));

    // empty regions
    for (int r = 3; r < `RP_N_REGIONS; r++)
    begin
      bus_read(reg_addr(r, int'($urandom % 64) * 4));
      assert (rd_data == 32'h0 && !rd_err)
      else report_mismatch($sformatf("region %0d read %h err %b", r, rd_data, rd_err));
    end

    // at unity gain the DAC shows the negated ADC sample
    bus_write(reg_addr(1, `RP_GEN_CTRL_OFS), 32'h0);
    bus_write(reg_addr(2, `RP_PID_SP_A_OFS), 32'h0);
    bus_write(reg_addr(2, `RP_PID_SP_B_OFS), 32'h0);
    set_gains(256);
    bus_read(reg_addr(2, `RP_PID_GAIN_B_OFS));
    assert (rd_data == 32'd256) else report_mismatch($sformatf("gain read %h", rd_data));
    check_adc_path(14'h0000, 14'h3FFF, 256);   // full scale both ways
    check_adc_path(14'h2000, 14'h1FFF, 256);
    for (int i = 0; i < 40; i++)
      check_adc_path(14'($urandom), 14'($urandom), 256);

    // controller saturation
    set_gains(4096);
    check_adc_path(14'h0000, 14'h3FFF, 4096);
    assert (dac_a == 14'h3FFF && dac_b == 14'h0000)
    else report_mismatch($sformatf("saturated dac %h/%h", dac_a, dac_b));
    for (int i = 0; i < 10; i++)
      check_adc_path(14'($urandom), 14'($urandom), 4096);

    // wave plus ctrl past the range with ctrl A +8191 and ctrl B -8191
    set_gains(256);
    adc_a = 14'h3FFF;
    adc_b = 14'h0000;
    bus_write(reg_addr(1, `RP_GEN_STEP_A_OFS), 32'h4000_0000);
    bus_write(reg_addr(1, `RP_GEN_STEP_B_OFS), 32'h4000_0000);
    bus_write(reg_addr(1, `RP_GEN_CTRL_OFS), 32'h3);
    sat_hits   = 0;
    low_hits_a = 0;
    for (int i = 0; i < 16; i++)
    begin
      @(negedge adc_clk);
      assert (in_sum_set(decode_code(dac_a), 8191))
      else report_mismatch($sformatf("dac A %h outside saturated sums", dac_a));
      assert (in_sum_set(decode_code(dac_b), -8191))
      else report_mismatch($sformatf("dac B %h outside saturated sums", dac_b));
      if (dac_b == 14'h3FFF)
        sat_hits++;
      if (dac_a == encode_sample(-1))    // wave minimum on A
        low_hits_a++;
    end
    assert (sat_hits > 0) else abort_run("sum on channel B never reached negative full scale");
    assert (low_hits_a > 0) else abort_run("wave on channel A never reached its minimum");

    // sawtooth with the controller muted
    bus_write(reg_addr(1, `RP_GEN_CTRL_OFS), 32'h0);
    set_gains(0);
    k_a = 1 + int'($urandom % 4095);
    k_b = 1 + int'($urandom % 4095);
    bus_write(reg_addr(1, `RP_GEN_STEP_A_OFS), 32'(k_a) << 18);
    bus_write(reg_addr(1, `RP_GEN_STEP_B_OFS), 32'(k_b) << 18);
    bus_write(reg_addr(1, `RP_GEN_CTRL_OFS), 32'h3);
    repeat (3) @(negedge adc_clk);       // let the ramp reach the pins
    prev_a = decode_code(dac_a);
    prev_b = decode_code(dac_b);
    for (int i = 0; i < 24; i++)
    begin
      @(negedge adc_clk);
      cur_a = decode_code(dac_a);
      cur_b = decode_code(dac_b);
      assert ((cur_a - prev_a + 2 * FULL) % FULL == k_a)
      else report_mismatch($sformatf("ramp A %0d -> %0d, step %0d", prev_a, cur_a, k_a));
      assert ((cur_b - prev_b + 2 * FULL) % FULL == k_b)
      else report_mismatch($sformatf("ramp B %0d -> %0d, step %0d", prev_b, cur_b, k_b));
      prev_a = cur_a;
      prev_b = cur_b;
    end
    bus_write(reg_addr(1, `RP_GEN_CTRL_OFS), 32'h2);   // A off, B keeps running
    check_dac_idle(1'b0);
    bus_write(reg_addr(1, `RP_GEN_CTRL_OFS), 32'h0);
    check_dac_idle(1'b1);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+logic
logic/rp_pkg.sv
logic/sys_bus_decoder.sv
logic/housekeeping_regs.sv
logic/sawtooth_gen.sv
logic/p_controller.sv
logic/analog_front.sv
logic/rp_top.sv
testbench/tb_rp_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_rp_top -Mdir obj_dir

# a failing run still prints, the search below decides
sim_out=$(./obj_dir/Vtb_rp_top || true)
echo "$sim_out"

if echo "$sim_out" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1
